// ==== files.f ====
+incdir+include
rtl/hazardPkg.sv
rtl/instrDecode.sv
rtl/stageTagPipe.sv
rtl/forwardUnit.sv
rtl/hazardTop.sv
sim/tbHazard.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tbHazard
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tbHazard.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module tbHazard;
	import hazardPkg::*;

	// Directed part needs well under 100 cycles
	localparam int RandCycles = 2000;
	localparam int CycleLimit = RandCycles + 1000;
	// Fetch enabled, no bubble
	localparam stallCtrlT StallRun  = 3'b110;
	// Fetch frozen, bubble into ID/EX
	localparam stallCtrlT StallHold = 3'b001;
	// Unknown opcode reading r31, which no directed test writes
	localparam instrT FillWord = {6'h3F, 5'd31, 5'd31, 16'h0000};

	logic      clk;
	logic      rstN;
	instrT     instr;
	logic      instrValid;
	fwdCtrlT   fwd;
	stallCtrlT stall;

	// Model of the shadow pipeline
	stageTagT  mIdEx;
	stageTagT  mExMem;
	stageTagT  mMemWb;
	stageTagT  mId;
	fwdCtrlT   expFwd;
	stallCtrlT expStall;

	int seed;
	int errors;
	int tests;
	int cycles;

	hazardTop u_dut (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.fwd        (fwd),
		.stall      (stall)
	);

	always #4 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// Decode rules of the ISA subset
	function automatic stageTagT decodeWord(input instrT w, input logic v);
		stageTagT t;
		t = '0;
		t.rs = w[25:21];
		t.rt = w[20:16];
		if (v) begin
			case (w[31:26])
				`OP_RTYPE: begin
					t.ctrl.regWrite = 1'b1;
					t.rd = w[15:11];
				end
				`OP_LW: begin
					t.ctrl.regWrite = 1'b1;
					t.ctrl.memRead = 1'b1;
					t.ctrl.memToReg = 1'b1;
					t.rd = w[20:16];
				end
				`OP_SW: t.ctrl.memWrite = 1'b1;
				`OP_BEQ, `OP_BNE: t.ctrl.branch = 1'b1;
				`OP_ADDI, `OP_ANDI, `OP_ORI: begin
					t.ctrl.regWrite = 1'b1;
					t.rd = w[20:16];
				end
				default: t.ctrl = '0;
			endcase
		end
		return t;
	endfunction

	// Load-use and branch stall, r0 included
	function automatic stallCtrlT stallRules(input stageTagT id, input stageTagT ex);
		logic      hit;
		stallCtrlT s;
		hit = (ex.ctrl.memRead && (ex.rt == id.rs || ex.rt == id.rt)) ||
			(id.ctrl.branch && ex.ctrl.regWrite && (ex.rd == id.rs || ex.rd == id.rt));
		s.pcEnable = !hit;
		s.ifIdEnable = !hit;
		s.idControlNop = hit;
		return s;
	endfunction

	function automatic fwdCtrlT fwdRules(input stageTagT id, input stageTagT ex,
		input stageTagT mem, input stageTagT wb);
		logic    eTerm;
		logic    wTerm;
		logic    lTerm;
		fwdCtrlT f;
		eTerm = mem.ctrl.regWrite && mem.rd != '0;
		wTerm = wb.ctrl.regWrite && wb.rd != '0;
		lTerm = wb.ctrl.memToReg && ex.ctrl.regWrite && wb.rt != '0;
		f.forwardA[1] = eTerm && mem.rd == ex.rs;
		f.forwardA[0] = (wTerm && mem.rd != ex.rs && wb.rd == ex.rs) ||
			(lTerm && wb.rt == ex.rs);
		f.forwardB[1] = eTerm && mem.rd == ex.rt;
		f.forwardB[0] = (wTerm && mem.rd != ex.rt && wb.rd == ex.rt) ||
			(lTerm && wb.rt == ex.rt);
		f.forwardMemToMem = mem.rt == wb.rt && wb.ctrl.memToReg && mem.ctrl.memWrite;
		f.forwardC = id.ctrl.branch && eTerm && mem.rd == id.rs;
		f.forwardD = id.ctrl.branch && eTerm && mem.rd == id.rt;
		// WB write seen by the ID read, load into rt or ALU into rd
		f.idWriteToRead[0] = (wb.ctrl.memToReg && wb.rt != '0 && wb.rt == id.rs) ||
			(wb.ctrl.regWrite && !wb.ctrl.memToReg && wb.rd == id.rs);
		f.idWriteToRead[1] = (wb.ctrl.memToReg && wb.rt != '0 && wb.rt == id.rt) ||
			(wb.ctrl.regWrite && !wb.ctrl.memToReg && wb.rd == id.rt);
		return f;
	endfunction

	assign mId = decodeWord(instr, instrValid);
	assign expStall = stallRules(mId, mIdEx);
	assign expFwd = fwdRules(mId, mIdEx, mExMem, mMemWb);

	// Model stages move on every edge, bubble on a stall
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mIdEx <= '0;
			mExMem <= '0;
			mMemWb <= '0;
		end else begin
			mIdEx <= expStall.idControlNop ? '0 : mId;
			mExMem <= mIdEx;
			mMemWb <= mExMem;
		end
	end

	function automatic instrT rWord(input regAddrT rd, input regAddrT rs, input regAddrT rt);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, 6'h20};
	endfunction

	function automatic instrT iWord(input logic [5:0] op, input regAddrT rs, input regAddrT rt);
		return {op, rs, rt, 16'h0004};
	endfunction

	// Known opcodes plus one illegal, registers 0 to 7
	function automatic instrT randomWord();
		int         pick;
		logic [5:0] op;
		regAddrT    rs;
		regAddrT    rt;
		regAddrT    rd;
		pick = $unsigned($random(seed)) % 9;
		case (pick)
			0: op = `OP_RTYPE;
			1: op = `OP_LW;
			2: op = `OP_SW;
			3: op = `OP_BEQ;
			4: op = `OP_BNE;
			5: op = `OP_ADDI;
			6: op = `OP_ANDI;
			7: op = `OP_ORI;
			default: op = 6'h3F;
		endcase
		rs = regAddrT'($unsigned($random(seed)) % 8);
		rt = regAddrT'($unsigned($random(seed)) % 8);
		rd = regAddrT'($unsigned($random(seed)) % 8);
		return {op, rs, rt, rd, 11'h020};
	endfunction

	task automatic compareField(input string where, input string field,
		input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s %s got %h expected %h at %0t", where, field, got, exp, $time);
		end
	endtask

	task automatic checkFwd(input string where, input fwdCtrlT got, input fwdCtrlT exp);
		compareField(where, "forwardA", got.forwardA, exp.forwardA);
		compareField(where, "forwardB", got.forwardB, exp.forwardB);
		compareField(where, "forwardMemToMem",
			{1'b0, got.forwardMemToMem}, {1'b0, exp.forwardMemToMem});
		compareField(where, "forwardC", {1'b0, got.forwardC}, {1'b0, exp.forwardC});
		compareField(where, "forwardD", {1'b0, got.forwardD}, {1'b0, exp.forwardD});
		compareField(where, "idWriteToRead", got.idWriteToRead, exp.idWriteToRead);
	endtask

	task automatic checkStall(input string where, input stallCtrlT got, input stallCtrlT exp);
		compareField(where, "pcEnable", {1'b0, got.pcEnable}, {1'b0, exp.pcEnable});
		compareField(where, "ifIdEnable", {1'b0, got.ifIdEnable}, {1'b0, exp.ifIdEnable});
		compareField(where, "idControlNop",
			{1'b0, got.idControlNop}, {1'b0, exp.idControlNop});
	endtask

	// New IF/ID word on the falling edge, outputs settled 1 ns later
	task automatic driveCycle(input instrT w, input logic v, input string where);
		@(negedge clk);
		instr = w;
		instrValid = v;
		#1;
		checkFwd(where, fwd, expFwd);
		checkStall(where, stall, expStall);
	endtask

	task automatic drainPipe();
		repeat (3) driveCycle(FillWord, 1'b1, "drain");
	endtask

	task automatic reportTest(input string name, input int e0);
		tests++;
		if (errors == e0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - e0);
		end
	endtask

	task automatic resetCheck();
		int e0;
		e0 = errors;
		@(negedge clk);
		rstN = 1'b1;
		#1;
		// Zero tags, R-type in ID
		checkFwd("reset", fwd, '0);
		checkStall("reset", stall, StallRun);
		reportTest("reset", e0);
	endtask

	task automatic aluChain();
		fwdCtrlT f;
		int      e0;
		e0 = errors;
		f = '0;
		drainPipe();
		// r1 = r2 + r3 straight into r4 = r1 + r5
		driveCycle(rWord(5'd1, 5'd2, 5'd3), 1'b1, "alu");
		driveCycle(rWord(5'd4, 5'd1, 5'd5), 1'b1, "alu");
		driveCycle(FillWord, 1'b1, "alu");
		f.forwardA = 2'b10;
		checkFwd("alu adjacent", fwd, f);
		checkStall("alu adjacent", stall, StallRun);
		drainPipe();
		// Independent r6 in between
		driveCycle(rWord(5'd1, 5'd2, 5'd3), 1'b1, "alu");
		driveCycle(rWord(5'd6, 5'd2, 5'd3), 1'b1, "alu");
		driveCycle(rWord(5'd4, 5'd1, 5'd5), 1'b1, "alu");
		driveCycle(FillWord, 1'b1, "alu");
		f.forwardA = 2'b01;
		checkFwd("alu gap", fwd, f);
		drainPipe();
		// Writes to r0 never forward
		driveCycle(rWord(5'd0, 5'd2, 5'd3), 1'b1, "alu");
		driveCycle(rWord(5'd4, 5'd0, 5'd5), 1'b1, "alu");
		driveCycle(FillWord, 1'b1, "alu");
		checkFwd("alu r0", fwd, '0);
		reportTest("aluChain", e0);
	endtask

	task automatic loadUse();
		fwdCtrlT f;
		int      e0;
		e0 = errors;
		f = '0;
		drainPipe();
		// lw r1 then r4 = r1 + r5
		driveCycle(iWord(`OP_LW, 5'd2, 5'd1), 1'b1, "load");
		driveCycle(rWord(5'd4, 5'd1, 5'd5), 1'b1, "load");
		checkFwd("load stall", fwd, f);
		checkStall("load stall", stall, StallHold);
		// Held word decoded again behind the bubble
		driveCycle(rWord(5'd4, 5'd1, 5'd5), 1'b1, "load");
		checkStall("load release", stall, StallRun);
		driveCycle(FillWord, 1'b1, "load");
		f.forwardA = 2'b01;
		checkFwd("load forward", fwd, f);
		reportTest("loadUse", e0);
	endtask

	task automatic branchStall();
		fwdCtrlT f;
		int      e0;
		e0 = errors;
		f = '0;
		drainPipe();
		// r1 = r2 + r3 then beq r1, r5
		driveCycle(rWord(5'd1, 5'd2, 5'd3), 1'b1, "branch");
		driveCycle(iWord(`OP_BEQ, 5'd1, 5'd5), 1'b1, "branch");
		checkFwd("branch stall", fwd, f);
		checkStall("branch stall", stall, StallHold);
		// Producer now in EX/MEM
		driveCycle(iWord(`OP_BEQ, 5'd1, 5'd5), 1'b1, "branch");
		f.forwardC = 1'b1;
		checkFwd("branch forward", fwd, f);
		checkStall("branch forward", stall, StallRun);
		reportTest("branchStall", e0);
	endtask

	task automatic loadThenStore();
		fwdCtrlT f;
		int      e0;
		e0 = errors;
		f = '0;
		drainPipe();
		// lw r3 then sw r3
		driveCycle(iWord(`OP_LW, 5'd2, 5'd3), 1'b1, "ldst");
		driveCycle(iWord(`OP_SW, 5'd4, 5'd3), 1'b1, "ldst");
		checkStall("ldst stall", stall, StallHold);
		driveCycle(iWord(`OP_SW, 5'd4, 5'd3), 1'b1, "ldst");
		// Reader of r3 in ID while the load writes back
		driveCycle(rWord(5'd6, 5'd3, 5'd7), 1'b1, "ldst");
		// Bubble sits between load and store, so no memory copy
		f.forwardB = 2'b01;
		f.idWriteToRead = 2'b01;
		checkFwd("ldst bypass", fwd, f);
		checkStall("ldst bypass", stall, StallRun);
		reportTest("loadThenStore", e0);
	endtask

	task automatic randomStream();
		int e0;
		int i;
		e0 = errors;
		for (i = 0; i < RandCycles; i++) begin
			if (expStall.idControlNop) begin
				// IF/ID frozen
				driveCycle(instr, instrValid, "random");
			end else begin
				driveCycle(randomWord(), ($unsigned($random(seed)) % 8) != 0, "random");
			end
		end
		reportTest("randomStream", e0);
	endtask

	initial begin
		seed = 32'h568;
		errors = 0;
		tests = 0;
		cycles = 0;
		clk = 1'b0;
		rstN = 1'b0;
		// R-type word waits in IF/ID through reset
		instr = rWord(5'd1, 5'd2, 5'd3);
		instrValid = 1'b1;
		repeat (4) @(posedge clk);
		resetCheck();
		aluChain();
		loadUse();
		branchStall();
		loadThenStore();
		randomStream();
		$display("errors %0d, tests %0d", errors, tests);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== rtl/hazardTop.sv ====
`timescale 1ns/1ps

module hazardTop (
	input  logic                 clk,
	input  logic                 rstN,
	input  hazardPkg::instrT     instr,
	input  logic                 instrValid,
	output hazardPkg::fwdCtrlT   fwd,
	output hazardPkg::stallCtrlT stall
);
	import hazardPkg::*;

	// Decoded IF/ID word
	stageTagT idTag;
	// Shadow pipeline entries
	stageTagT idExTag;
	stageTagT exMemTag;
	stageTagT memWbTag;

	instrDecode u_decode (
		.instr      (instr),
		.instrValid (instrValid),
		.idTag      (idTag)
	);

	// Bubble request comes back from the hazard logic
	stageTagPipe u_tagPipe (
		.clk          (clk),
		.rstN         (rstN),
		.idTag        (idTag),
		.idControlNop (stall.idControlNop),
		.idExTag      (idExTag),
		.exMemTag     (exMemTag),
		.memWbTag     (memWbTag)
	);

	// Purely combinational, same cycle as the tags
	forwardUnit u_fwdUnit (
		.idTag    (idTag),
		.idExTag  (idExTag),
		.exMemTag (exMemTag),
		.memWbTag (memWbTag),
		.fwd      (fwd),
		.stall    (stall)
	);

endmodule

// ==== rtl/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
	input  hazardPkg::stageTagT  idTag,
	input  hazardPkg::stageTagT  idExTag,
	input  hazardPkg::stageTagT  exMemTag,
	input  hazardPkg::stageTagT  memWbTag,
	output hazardPkg::fwdCtrlT   fwd,
	output hazardPkg::stallCtrlT stall
);
	import hazardPkg::*;

	// EX/MEM holds a live register write
	logic exWrites;
	// Load-use dependence on the instruction in EX
	logic loadUse;
	// Branch in ID needs a result still in EX
	logic branchDep;
	logic stallNow;

	// Operand select for one EX source register
	function automatic fwdSelT aluSel(
		input regAddrT  src,
		input stageTagT exTag,
		input stageTagT wbTag,
		input logic     exRegWrite
	);
		logic   eHit;
		logic   wHit;
		logic   lHit;
		fwdSelT sel;
		// E, W and L terms of the forwarding equations
		eHit = exTag.ctrl.regWrite && (exTag.rd != '0);
		wHit = wbTag.ctrl.regWrite && (wbTag.rd != '0);
		lHit = wbTag.ctrl.memToReg && exRegWrite && (wbTag.rt != '0);
		// Newest producer first
		sel[1] = eHit && (exTag.rd == src);
		// Older producer, both bits may end up set
		sel[0] = (wHit && (exTag.rd != src) && (wbTag.rd == src)) ||
			(lHit && (wbTag.rt == src));
		return sel;
	endfunction

	// Register file write in WB seen by a read in ID
	function automatic logic wbBypass(
		input regAddrT  src,
		input stageTagT wbTag
	);
		logic loadHit;
		logic aluHit;
		// Load result lands in rt
		loadHit = wbTag.ctrl.memToReg && (wbTag.rt != '0) && (wbTag.rt == src);
		// ALU result lands in rd
		aluHit  = wbTag.ctrl.regWrite && !wbTag.ctrl.memToReg && (wbTag.rd == src);
		return loadHit || aluHit;
	endfunction

	assign exWrites = exMemTag.ctrl.regWrite && (exMemTag.rd != '0);

	// Register zero is not excluded here
	assign loadUse = idExTag.ctrl.memRead &&
		((idExTag.rt == idTag.rs) || (idExTag.rt == idTag.rt));
	assign branchDep = idTag.ctrl.branch && idExTag.ctrl.regWrite &&
		((idExTag.rd == idTag.rs) || (idExTag.rd == idTag.rt));
	assign stallNow = loadUse || branchDep;

	always_comb begin
		// ALU operand sources for the instruction in EX
		fwd.forwardA = aluSel(idExTag.rs, exMemTag, memWbTag, idExTag.ctrl.regWrite);
		fwd.forwardB = aluSel(idExTag.rt, exMemTag, memWbTag, idExTag.ctrl.regWrite);

		// Loaded value copied straight into the following store
		fwd.forwardMemToMem = (exMemTag.rt == memWbTag.rt) &&
			memWbTag.ctrl.memToReg && exMemTag.ctrl.memWrite;

		// Branch comparator operands from EX/MEM
		fwd.forwardC = idTag.ctrl.branch && exWrites && (exMemTag.rd == idTag.rs);
		fwd.forwardD = idTag.ctrl.branch && exWrites && (exMemTag.rd == idTag.rt);

		fwd.idWriteToRead[0] = wbBypass(idTag.rs, memWbTag);
		fwd.idWriteToRead[1] = wbBypass(idTag.rt, memWbTag);
	end

	// Freeze fetch and push a bubble for one stall cycle
	always_comb begin
		stall.pcEnable     = !stallNow;
		stall.ifIdEnable   = !stallNow;
		stall.idControlNop = stallNow;
	end

endmodule

// ==== rtl/stageTagPipe.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module stageTagPipe (
	input  logic                clk,
	input  logic                rstN,
	input  hazardPkg::stageTagT idTag,
	input  logic                idControlNop,
	output hazardPkg::stageTagT idExTag,
	output hazardPkg::stageTagT exMemTag,
	output hazardPkg::stageTagT memWbTag
);
	import hazardPkg::*;

	// Entry that ID/EX takes on the next edge
	stageTagT idExNext;

	// Stall turns the ID slot into a bubble
	// The held IF/ID word is decoded again next cycle
	always_comb begin
		if (idControlNop) begin
			idExNext = `TAG_RESET;
		end else begin
			idExNext = idTag;
		end
	end

	// ID/EX register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idExTag <= `TAG_RESET;
		end else begin
			idExTag <= idExNext;
		end
	end

	// EX/MEM register, never holds
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMemTag <= `TAG_RESET;
		end else begin
			exMemTag <= idExTag;
		end
	end

	// MEM/WB register
	// Tag arrives here three edges after leaving ID
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWbTag <= `TAG_RESET;
		end else begin
			memWbTag <= exMemTag;
		end
	end

endmodule

// ==== rtl/instrDecode.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module instrDecode (
	input  hazardPkg::instrT    instr,
	input  logic                instrValid,
	output hazardPkg::stageTagT idTag
);
	import hazardPkg::*;

	// Raw fields of the word
	opcodeT   opcode;
	regAddrT  rsField;
	regAddrT  rtField;
	regAddrT  rdField;

	// Decoded control and write target
	ctrlBitsT ctrl;
	regAddrT  dest;

	// Field split, same positions for every format
	assign opcode  = instr[31:26];
	assign rsField = instr[25:21];
	assign rtField = instr[20:16];
	assign rdField = instr[15:11];

	always_comb begin
		// Nothing happens unless the opcode is known
		ctrl = `CTRL_IDLE;
		dest = '0;
		if (instrValid) begin
			case (opcode)
				`OP_RTYPE: begin
					// ALU op, result goes to rd
					ctrl.regWrite = 1'b1;
					dest          = rdField;
				end
				`OP_LW: begin
					// Load writes rt from memory
					ctrl.regWrite = 1'b1;
					ctrl.memRead  = 1'b1;
					ctrl.memToReg = 1'b1;
					dest          = rtField;
				end
				`OP_SW: begin
					// Store reads rt, no register write
					ctrl.memWrite = 1'b1;
				end
				`OP_BEQ, `OP_BNE: begin
					// Compare only, resolution lives elsewhere
					ctrl.branch = 1'b1;
				end
				`OP_ADDI, `OP_ANDI, `OP_ORI: begin
					// Immediate forms target rt
					ctrl.regWrite = 1'b1;
					dest          = rtField;
				end
				default: begin
					// Unknown opcode acts as a NOP
					ctrl = `CTRL_IDLE;
				end
			endcase
		end
	end

	// Source fields pass through even for a NOP
	always_comb begin
		idTag.ctrl = ctrl;
		idTag.rs   = rsField;
		idTag.rt   = rtField;
		idTag.rd   = dest;
	end

endmodule

// ==== rtl/hazardPkg.sv ====
`include "hazard_settings.svh"

package hazardPkg;

	// Register number as found in rs, rt and rd fields
	typedef logic [`REG_ADDR_W-1:0] regAddrT;

	// Raw word from the IF/ID register
	typedef logic [31:0] instrT;

	// Primary opcode field
	typedef logic [`OP_W-1:0] opcodeT;

	// ALU operand source
	// 00 register file, 10 EX/MEM result, 01 MEM/WB result
	typedef logic [1:0] fwdSelT;

	// Control bits that travel with an instruction
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memToReg;
		logic memWrite;
		logic branch;
	} ctrlBitsT;

	// One stage entry of the shadow pipeline, rd is the write target
	typedef struct packed {
		ctrlBitsT ctrl;
		regAddrT  rs;
		regAddrT  rt;
		regAddrT  rd;
	} stageTagT;

	// Forwarding selects towards the datapath
	typedef struct packed {
		fwdSelT     forwardA;
		fwdSelT     forwardB;
		logic       forwardMemToMem;
		logic       forwardC;
		logic       forwardD;
		// Bit 0 for rs, bit 1 for rt
		logic [1:0] idWriteToRead;
	} fwdCtrlT;

	// Stall enables and ID/EX bubble request
	typedef struct packed {
		logic pcEnable;
		logic ifIdEnable;
		logic idControlNop;
	} stallCtrlT;

endpackage

// ==== include/hazard_settings.svh ====
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// Register number width, fixed by the ISA
`define REG_ADDR_W 5
// Primary opcode field width
`define OP_W 6

// Primary opcodes in bits 31:26
`define OP_RTYPE 6'h00
`define OP_LW    6'h23
`define OP_SW    6'h2B
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D

// Tag value after reset, also used as the bubble
`define TAG_RESET '0
// Control set of an invalid or unknown word
`define CTRL_IDLE '0

`endif
